//--- design/mem_settings.svh
/*
 * Memory map and harness settings
 * RAM size, pseudo-peripheral addresses, the pass code and the
 * interrupt id used by the timer.
 */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address width of the RAM, 16 KiB
`define MEM_RAM_ADDR_WIDTH 14

// pseudo-peripheral addresses
`define MEM_PRINT_ADDR  32'h1000_0000
`define MEM_TIMER_ADDR  32'h1500_0000
`define MEM_STATUS_ADDR 32'h2000_0000
`define MEM_EXIT_ADDR   32'h2000_0004

// value written to the status register by a passing test
`define MEM_PASS_CODE 32'd123456789

`define MEM_TIMER_IRQ_ID 5'd7

`endif

//--- design/core_mem_pkg.sv
/*
 * Core memory types
 * Bus word seen either as a full word or as four byte lanes.
 */
`default_nettype none

package core_mem_pkg;

    // lane[i] is the byte selected by byte enable bit i
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;
    } bus_word_u;

endpackage

`default_nettype wire

//--- design/mem_bus_if.sv
/*
 * Memory bus port
 * One req/gnt/rvalid request and response port between a master
 * and a slave inside the memory side of the harness.
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if (
    input wire logic clk_i,
    input wire logic rst_i
);
    logic        req;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic        gnt;
    logic [31:0] rdata;
    logic        rvalid;

    modport master (output req, addr, we, be, wdata, input gnt, rdata, rvalid);
    modport slave (input req, addr, we, be, wdata, output gnt, rdata, rvalid);

    // a response only ever follows an accepted request by one cycle
    a_rvalid_after_accept: assert property (
        @(posedge clk_i) disable iff (rst_i) rvalid |-> $past(req && gnt)
    );

endinterface

`default_nettype wire

//--- design/dp_ram.sv
/*
 * Dual-port RAM
 * Word-organized code and data memory. The instruction port only reads,
 * the data port reads and writes with byte enables. Both ports answer
 * one cycle after the request.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module dp_ram (
    input  wire logic                           clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           instr_req_i,
    input  wire logic [`MEM_RAM_ADDR_WIDTH-1:0] instr_addr_i,
    output logic                                instr_gnt_o,
    output logic                                instr_rvalid_o,
    output logic [31:0]                         instr_rdata_o,
    mem_bus_if.slave                            data
);
    import core_mem_pkg::*;

    localparam int WORDS = 2 ** (`MEM_RAM_ADDR_WIDTH - 2);

    logic [31:0] mem [0:WORDS-1];

    logic [`MEM_RAM_ADDR_WIDTH-3:0] instr_idx;
    logic [`MEM_RAM_ADDR_WIDTH-3:0] data_idx;
    bus_word_u                      old_word;
    bus_word_u                      new_word;
    bus_word_u                      merged;

    assign instr_idx   = instr_addr_i[`MEM_RAM_ADDR_WIDTH-1:2];
    assign data_idx    = data.addr[`MEM_RAM_ADDR_WIDTH-1:2];
    assign instr_gnt_o = instr_req_i;
    assign data.gnt    = data.req;

    // only the enabled byte lanes take the new data
    always_comb begin
        old_word.word = mem[data_idx];
        new_word.word = data.wdata;
        merged        = old_word;
        for (int i = 0; i < 4; i++) begin
            if (data.be[i]) begin
                merged.lane[i] = new_word.lane[i];
            end
        end
    end

    // the instruction read sees the old word on a same-cycle write
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            instr_rdata_o <= mem[instr_idx];
        end
        if (data.req && data.we) begin
            mem[data_idx] <= merged.word;
        end else if (data.req) begin
            data.rdata <= mem[data_idx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_o <= 1'b0;
            data.rvalid    <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data.rvalid    <= data.req;
        end
    end

endmodule

`default_nettype wire

//--- design/data_addr_decode.sv
/*
 * Data address decoder
 * Routes each data request to the RAM or the control registers and
 * returns the matching response. Unmapped accesses are answered here
 * with zero data and raise a sticky bus error.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module data_addr_decode (
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        data_req_i,
    input  wire logic [31:0] data_addr_i,
    input  wire logic        data_we_i,
    input  wire logic [3:0]  data_be_i,
    input  wire logic [31:0] data_wdata_i,
    output logic             data_gnt_o,
    output logic             data_rvalid_o,
    output logic [31:0]      data_rdata_o,
    output logic             bus_error_o,
    mem_bus_if.master        ram_bus,
    mem_bus_if.master        reg_bus
);
    localparam logic [1:0] CLS_NONE = 2'd0;
    localparam logic [1:0] CLS_RAM  = 2'd1;
    localparam logic [1:0] CLS_REG  = 2'd2;
    localparam logic [1:0] CLS_ERR  = 2'd3;

    logic       is_ram;
    logic       is_reg;
    logic [1:0] req_class;
    logic [1:0] resp_class;

    assign is_ram = (data_addr_i[31:`MEM_RAM_ADDR_WIDTH] == '0);
    assign is_reg = (data_addr_i == `MEM_PRINT_ADDR) || (data_addr_i == `MEM_STATUS_ADDR)
                 || (data_addr_i == `MEM_EXIT_ADDR) || (data_addr_i == `MEM_TIMER_ADDR);

    always_comb begin
        if (!data_req_i)  req_class = CLS_NONE;
        else if (is_ram)  req_class = CLS_RAM;
        else if (is_reg)  req_class = CLS_REG;
        else              req_class = CLS_ERR;
    end

    // request fields go to both targets, only one sees req
    assign ram_bus.req   = data_req_i && is_ram;
    assign ram_bus.addr  = data_addr_i;
    assign ram_bus.we    = data_we_i;
    assign ram_bus.be    = data_be_i;
    assign ram_bus.wdata = data_wdata_i;
    assign reg_bus.req   = data_req_i && is_reg;
    assign reg_bus.addr  = data_addr_i;
    assign reg_bus.we    = data_we_i;
    assign reg_bus.be    = data_be_i;
    assign reg_bus.wdata = data_wdata_i;

    always_comb begin
        case (req_class)
            CLS_RAM: data_gnt_o = ram_bus.gnt;
            CLS_REG: data_gnt_o = reg_bus.gnt;
            CLS_ERR: data_gnt_o = 1'b1;
            default: data_gnt_o = 1'b0;
        endcase
    end

    // remember where the accepted request went for the response cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_class  <= CLS_NONE;
            bus_error_o <= 1'b0;
        end else begin
            resp_class <= data_gnt_o ? req_class : CLS_NONE;
            if (req_class == CLS_ERR) begin
                bus_error_o <= 1'b1;
            end
        end
    end

    always_comb begin
        case (resp_class)
            CLS_RAM: begin
                data_rvalid_o = ram_bus.rvalid;
                data_rdata_o  = ram_bus.rdata;
            end
            CLS_REG: begin
                data_rvalid_o = reg_bus.rvalid;
                data_rdata_o  = reg_bus.rdata;
            end
            CLS_ERR: begin
                data_rvalid_o = 1'b1;
                data_rdata_o  = 32'd0;
            end
            default: begin
                data_rvalid_o = 1'b0;
                data_rdata_o  = 32'd0;
            end
        endcase
    end

    a_one_target: assert property (
        @(posedge clk_i) disable iff (rst_i) !(ram_bus.req && reg_bus.req)
    );

endmodule

`default_nettype wire

//--- design/sim_ctrl_regs.sv
/*
 * Simulation control registers
 * Print port, test status, exit value and timer load at fixed
 * addresses. Writes become one-cycle pulses or held values, reads
 * return the remaining timer count.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module sim_ctrl_regs (
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    mem_bus_if.slave         bus,
    output logic             timer_load_o,
    output logic [31:0]      timer_count_o,
    input  wire logic [31:0] timer_remaining_i,
    output logic             print_valid_o,
    output logic [7:0]       print_char_o,
    output logic             tests_passed_o,
    output logic             tests_failed_o,
    output logic             exit_valid_o,
    output logic [31:0]      exit_value_o
);
    import core_mem_pkg::*;

    logic      wr;
    logic      wr_status;
    bus_word_u wdata_w;

    assign bus.gnt   = bus.req;
    assign wr        = bus.req && bus.we;
    assign wr_status = wr && (bus.addr == `MEM_STATUS_ADDR);
    assign wdata_w   = bus.wdata;

    // the timer picks up the load at the end of the accepting cycle
    assign timer_load_o  = wr && (bus.addr == `MEM_TIMER_ADDR);
    assign timer_count_o = bus.wdata;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus.rvalid     <= 1'b0;
            print_valid_o  <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= 32'd0;
        end else begin
            bus.rvalid     <= bus.req;
            print_valid_o  <= wr && (bus.addr == `MEM_PRINT_ADDR);
            tests_passed_o <= wr_status && (bus.wdata == `MEM_PASS_CODE);
            tests_failed_o <= wr_status && (bus.wdata != `MEM_PASS_CODE);
            exit_valid_o   <= wr && (bus.addr == `MEM_EXIT_ADDR);
            if (wr && (bus.addr == `MEM_EXIT_ADDR)) begin
                exit_value_o <= bus.wdata;
            end
        end
    end

    // only the timer has anything to read back
    always_ff @(posedge clk_i) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= (bus.addr == `MEM_TIMER_ADDR) ? timer_remaining_i : 32'd0;
        end
        if (wr && (bus.addr == `MEM_PRINT_ADDR)) begin
            print_char_o <= wdata_w.lane[0];
        end
    end

    a_status_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i) !(tests_passed_o && tests_failed_o)
    );

endmodule

`default_nettype wire

//--- design/timer_irq.sv
/*
 * Countdown timer
 * Counts a loaded value down to zero and then holds a level interrupt
 * until the core acknowledges the timer id.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module timer_irq (
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        load_i,
    input  wire logic [31:0] count_i,
    input  wire logic        irq_ack_i,
    input  wire logic [4:0]  irq_id_i,
    output logic [31:0]      remaining_o,
    output logic             irq_timer_o
);
    logic ack_hit;

    assign ack_hit = irq_ack_i && (irq_id_i == `MEM_TIMER_IRQ_ID);

    // a load restarts the count and drops any pending interrupt, zero just stops
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            remaining_o <= 32'd0;
            irq_timer_o <= 1'b0;
        end else if (load_i) begin
            remaining_o <= count_i;
            irq_timer_o <= 1'b0;
        end else begin
            if (remaining_o != 32'd0) begin
                remaining_o <= remaining_o - 32'd1;
            end
            if (remaining_o == 32'd1) begin
                irq_timer_o <= 1'b1;
            end else if (ack_hit) begin
                irq_timer_o <= 1'b0;
            end
        end
    end

    a_irq_at_zero: assert property (
        @(posedge clk_i) disable iff (rst_i) $rose(irq_timer_o) |-> (remaining_o == 32'd0)
    );

endmodule

`default_nettype wire

//--- design/core_mem_wrapper.sv
/*
 * Core memory wrapper
 * Memory side of the core harness. Instruction and data ports of the
 * core come in as plain ports; behind them sit the RAM, the data
 * decoder, the control registers and the timer.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module core_mem_wrapper (
    input  wire logic        clk_i,
    input  wire logic        rst_i,

    input  wire logic        instr_req_i,
    input  wire logic [31:0] instr_addr_i,
    output logic             instr_gnt_o,
    output logic             instr_rvalid_o,
    output logic [31:0]      instr_rdata_o,

    input  wire logic        data_req_i,
    input  wire logic [31:0] data_addr_i,
    input  wire logic        data_we_i,
    input  wire logic [3:0]  data_be_i,
    input  wire logic [31:0] data_wdata_i,
    output logic             data_gnt_o,
    output logic             data_rvalid_o,
    output logic [31:0]      data_rdata_o,

    input  wire logic        irq_ack_i,
    input  wire logic [4:0]  irq_id_i,
    output logic             irq_timer_o,
    output logic             bus_error_o,
    output logic             print_valid_o,
    output logic [7:0]       print_char_o,
    output logic             tests_passed_o,
    output logic             tests_failed_o,
    output logic             exit_valid_o,
    output logic [31:0]      exit_value_o
);
    logic        timer_load;
    logic [31:0] timer_count;
    logic [31:0] timer_remaining;

    mem_bus_if ram_bus (.clk_i(clk_i), .rst_i(rst_i));
    mem_bus_if reg_bus (.clk_i(clk_i), .rst_i(rst_i));

    data_addr_decode u_data_addr_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .data_req_i   (data_req_i),
        .data_addr_i  (data_addr_i),
        .data_we_i    (data_we_i),
        .data_be_i    (data_be_i),
        .data_wdata_i (data_wdata_i),
        .data_gnt_o   (data_gnt_o),
        .data_rvalid_o(data_rvalid_o),
        .data_rdata_o (data_rdata_o),
        .bus_error_o  (bus_error_o),
        .ram_bus      (ram_bus),
        .reg_bus      (reg_bus)
    );

    // the instruction port only ever reaches the RAM
    dp_ram u_dp_ram (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_req_i   (instr_req_i),
        .instr_addr_i  (instr_addr_i[`MEM_RAM_ADDR_WIDTH-1:0]),
        .instr_gnt_o   (instr_gnt_o),
        .instr_rvalid_o(instr_rvalid_o),
        .instr_rdata_o (instr_rdata_o),
        .data          (ram_bus)
    );

    sim_ctrl_regs u_sim_ctrl_regs (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .bus              (reg_bus),
        .timer_load_o     (timer_load),
        .timer_count_o    (timer_count),
        .timer_remaining_i(timer_remaining),
        .print_valid_o    (print_valid_o),
        .print_char_o     (print_char_o),
        .tests_passed_o   (tests_passed_o),
        .tests_failed_o   (tests_failed_o),
        .exit_valid_o     (exit_valid_o),
        .exit_value_o     (exit_value_o)
    );

    timer_irq u_timer_irq (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .load_i     (timer_load),
        .count_i    (timer_count),
        .irq_ack_i  (irq_ack_i),
        .irq_id_i   (irq_id_i),
        .remaining_o(timer_remaining),
        .irq_timer_o(irq_timer_o)
    );

endmodule

`default_nettype wire

//--- test/tb_core_mem_wrapper.sv
/*
 * Testbench for the core memory wrapper
 * Plays the core on the instruction and data ports, checks RAM contents
 * against a reference model and exercises the print, status, exit,
 * timer and unmapped paths.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module tb_core_mem_wrapper;
    // the tests take roughly 350 cycles, this leaves a wide margin
    localparam int          MAX_CYCLES = 3000;
    localparam int          TIMER_N    = 20;
    localparam int          WIN_WORDS  = 32;
    localparam logic [31:0] WIN_BASE   = 32'h0000_0100;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        instr_req_i;
    logic [31:0] instr_addr_i;
    logic        instr_gnt_o;
    logic        instr_rvalid_o;
    logic [31:0] instr_rdata_o;
    logic        data_req_i;
    logic [31:0] data_addr_i;
    logic        data_we_i;
    logic [3:0]  data_be_i;
    logic [31:0] data_wdata_i;
    logic        data_gnt_o;
    logic        data_rvalid_o;
    logic [31:0] data_rdata_o;
    logic        irq_ack_i;
    logic [4:0]  irq_id_i;
    logic        irq_timer_o;
    logic        bus_error_o;
    logic        print_valid_o;
    logic [7:0]  print_char_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    logic [31:0] exit_value_o;

    int          error_count = 0;
    int          cycle_count = 0;
    integer      seed = 32'hc5b8;
    logic [31:0] ref_mem [0:2**(`MEM_RAM_ADDR_WIDTH-2)-1];

    core_mem_wrapper u_core_mem_wrapper (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic report_failure(input string what);
        error_count++;
        $display("Error: %s at cycle %0d", what, cycle_count);
    endtask

    task automatic expect_word(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            error_count++;
            $display("Mismatch in %s: expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic expect_bit(input string test, input logic exp, input logic act);
        assert (act === exp) else begin
            error_count++;
            $display("Mismatch in %s: expected %b, actual %b", test, exp, act);
        end
    endtask

    // byte lane i takes the new byte only where be[i] is set
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // one data request from a falling edge up to its response a cycle after acceptance
    task automatic data_xfer(input logic we, input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited       = 0;
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_addr_i  = addr;
        data_be_i    = be;
        data_wdata_i = wdata;
        @(posedge clk_i);
        while (!data_gnt_o && waited < 16) begin
            waited++;
            @(posedge clk_i);
        end
        assert (data_gnt_o) else report_failure("data request was never granted");
        @(negedge clk_i);
        data_req_i = 1'b0;
        assert (data_rvalid_o)
            else report_failure("no data response one cycle after acceptance");
        rdata = data_rdata_o;
    endtask

    task automatic instr_fetch(input logic [31:0] addr, output logic [31:0] rdata);
        int waited;
        waited       = 0;
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        @(posedge clk_i);
        while (!instr_gnt_o && waited < 16) begin
            waited++;
            @(posedge clk_i);
        end
        @(negedge clk_i);
        instr_req_i = 1'b0;
        assert (instr_rvalid_o)
            else report_failure("no instruction response one cycle after acceptance");
        rdata = instr_rdata_o;
    endtask

    task automatic ram_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        logic [31:0] unused_rd;
        data_xfer(1'b1, addr, be, wdata, unused_rd);
        ref_mem[addr[`MEM_RAM_ADDR_WIDTH-1:2]] =
            merge_lanes(ref_mem[addr[`MEM_RAM_ADDR_WIDTH-1:2]], wdata, be);
    endtask

    task automatic ram_check(input string test, input logic [31:0] addr);
        logic [31:0] rd;
        data_xfer(1'b0, addr, 4'hf, 32'd0, rd);
        expect_word(test, ref_mem[addr[`MEM_RAM_ADDR_WIDTH-1:2]], rd);
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_rd;
        data_xfer(1'b1, addr, 4'hf, wdata, unused_rd);
    endtask

    a_instr_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_gnt_o == instr_req_i)
        else report_failure("instruction grant does not follow the request");
    a_data_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        data_req_i |-> data_gnt_o)
        else report_failure("data request not granted in the same cycle");
    a_data_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        data_req_i |=> data_rvalid_o)
        else report_failure("data response missing after an accepted request");
    a_data_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !data_req_i |=> !data_rvalid_o)
        else report_failure("data response without a request");
    a_instr_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_req_i |=> instr_rvalid_o)
        else report_failure("instruction response missing after a fetch");
    a_print_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        print_valid_o |=> !print_valid_o)
        else report_failure("print strobe lasted longer than one cycle");
    a_status_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        (tests_passed_o || tests_failed_o) |=> !(tests_passed_o || tests_failed_o))
        else report_failure("status strobe lasted longer than one cycle");

    initial begin
        logic [31:0] rd;
        logic [31:0] addr;
        logic [31:0] rnd;
        logic [31:0] wd;
        int          l_cyc;
        int          r_cyc;
        rst_i        = 1'b1;
        instr_req_i  = 1'b0;
        instr_addr_i = 32'd0;
        data_req_i   = 1'b0;
        data_addr_i  = 32'd0;
        data_we_i    = 1'b0;
        data_be_i    = 4'd0;
        data_wdata_i = 32'd0;
        irq_ack_i    = 1'b0;
        irq_id_i     = 5'd0;
        repeat (16) @(negedge clk_i);
        expect_bit("reset irq", 1'b0, irq_timer_o);
        expect_bit("reset bus error", 1'b0, bus_error_o);
        expect_bit("reset data rvalid", 1'b0, data_rvalid_o);
        expect_bit("reset instr rvalid", 1'b0, instr_rvalid_o);
        expect_bit("reset exit valid", 1'b0, exit_valid_o);
        expect_word("reset exit value", 32'd0, exit_value_o);
        rst_i = 1'b0;

        // give every word of the test window a known value first
        for (int i = 0; i < WIN_WORDS; i++) begin
            addr = WIN_BASE + i * 4;
            ram_write(addr, 4'hf, (addr * 32'h9e37_79b9) ^ 32'h0f1e_2d3c);
        end

        ram_write(WIN_BASE + 32'h0, 4'b0001, 32'h1122_3344);
        ram_write(WIN_BASE + 32'h4, 4'b0110, 32'haabb_ccdd);
        ram_write(WIN_BASE + 32'h8, 4'b1000, 32'h5566_7788);
        ram_write(WIN_BASE + 32'hc, 4'b1010, 32'hcafe_f00d);
        ram_write(WIN_BASE + 32'h4, 4'b1001, 32'h0102_0304);
        for (int i = 0; i < 4; i++) begin
            ram_check("byte enable read", WIN_BASE + i * 4);
        end

        for (int i = 0; i < 4; i++) begin
            addr = WIN_BASE + i * 4;
            instr_fetch(addr, rd);
            expect_word("instruction fetch", ref_mem[addr[`MEM_RAM_ADDR_WIDTH-1:2]], rd);
        end

        reg_write(`MEM_PRINT_ADDR, 32'h0000_0a41);
        expect_bit("print valid", 1'b1, print_valid_o);
        expect_word("print char", 32'h0000_0041, {24'd0, print_char_o});
        @(negedge clk_i);
        reg_write(`MEM_STATUS_ADDR, `MEM_PASS_CODE);
        expect_bit("tests passed", 1'b1, tests_passed_o);
        expect_bit("tests passed alone", 1'b0, tests_failed_o);
        @(negedge clk_i);
        reg_write(`MEM_STATUS_ADDR, 32'hdead_beef);
        expect_bit("tests failed", 1'b1, tests_failed_o);
        expect_bit("tests failed alone", 1'b0, tests_passed_o);
        @(negedge clk_i);
        reg_write(`MEM_EXIT_ADDR, 32'h0000_002a);
        expect_bit("exit valid", 1'b1, exit_valid_o);
        expect_word("exit value", 32'h0000_002a, exit_value_o);
        @(negedge clk_i);
        expect_bit("exit pulse width", 1'b0, exit_valid_o);
        expect_word("exit value held", 32'h0000_002a, exit_value_o);

        // the count is loaded at acceptance and drops by one every cycle after
        l_cyc = cycle_count;
        reg_write(`MEM_TIMER_ADDR, TIMER_N);
        for (int k = 0; k < 3; k++) begin
            r_cyc = cycle_count;
            data_xfer(1'b0, `MEM_TIMER_ADDR, 4'hf, 32'd0, rd);
            expect_word("timer count", TIMER_N - (r_cyc - l_cyc - 1), rd);
        end
        while (!irq_timer_o && cycle_count - l_cyc < 2 * TIMER_N) begin
            @(negedge clk_i);
        end
        expect_word("timer irq delay", TIMER_N + 1, cycle_count - l_cyc);
        irq_ack_i = 1'b1;
        irq_id_i  = 5'd3;
        @(negedge clk_i);
        irq_ack_i = 1'b0;
        expect_bit("irq kept on wrong id", 1'b1, irq_timer_o);
        irq_ack_i = 1'b1;
        irq_id_i  = `MEM_TIMER_IRQ_ID;
        @(negedge clk_i);
        irq_ack_i = 1'b0;
        expect_bit("irq cleared on ack", 1'b0, irq_timer_o);

        for (int n = 0; n < 200; n++) begin
            rnd  = $random(seed);
            wd   = $random(seed);
            addr = WIN_BASE + {25'd0, rnd[4:0], 2'b00};
            if (rnd[5]) begin
                ram_write(addr, rnd[9:6], wd);
            end else begin
                ram_check("random read", addr);
            end
        end

        expect_bit("no bus error yet", 1'b0, bus_error_o);
        data_xfer(1'b0, 32'h3000_0000, 4'hf, 32'd0, rd);
        expect_word("unmapped read data", 32'd0, rd);
        expect_bit("bus error set", 1'b1, bus_error_o);
        @(negedge clk_i);
        expect_bit("bus error sticky", 1'b1, bus_error_o);

        $display("Run done: %0d errors in %0d cycles", error_count, cycle_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- core_mem.f
+incdir+design
design/core_mem_pkg.sv
design/mem_bus_if.sv
design/dp_ram.sv
design/data_addr_decode.sv
design/sim_ctrl_regs.sv
design/timer_irq.sv
design/core_mem_wrapper.sv
test/tb_core_mem_wrapper.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_core_mem_wrapper
FILELIST  := core_mem.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)
